// File: hdl/alu_pkg.sv
package alu_pkg;

    // ALU opcodes, codes 12 to 15 are unused
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_neg  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_slt  = 4'd6,
        op_sltu = 4'd7,
        op_ne   = 4'd8,
        op_sll  = 4'd9,
        op_srl  = 4'd10,
        op_sra  = 4'd11
    } alu_op_e;

    typedef logic [2:0] reg_addr_t;

    typedef struct packed {
        logic        is_imm;    // 0 here
        logic [3:0]  op;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [1:0]  pad;
    } instr_rr_t;

    typedef struct packed {
        logic        is_imm;    // 1 here
        logic [3:0]  op;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        logic signed [4:0] imm;
    } instr_ri_t;

    typedef union packed {
        instr_rr_t rr;
        instr_ri_t ri;
    } instr_t;

endpackage

// File: hdl/add_sub.sv
`timescale 1ns/1ps

module add_sub #(
    parameter int BW = 8
) (
    input  logic          sub,
    input  logic [BW-1:0] a,
    input  logic [BW-1:0] b,
    output logic [BW-1:0] sum,
    output logic          overflow
);

    logic [BW-1:0] b_eff;

    // a - b as a + ~b + 1
    assign b_eff = sub ? ~b : b;
    assign sum   = a + b_eff + BW'(sub);

    // same operand signs, different result sign
    assign overflow = (a[BW-1] == b_eff[BW-1]) && (sum[BW-1] != a[BW-1]);

endmodule

// File: hdl/shifter.sv
`timescale 1ns/1ps

module shifter #(
    parameter int BW = 8,
    parameter int SW = $clog2(BW)
) (
    input  logic [BW-1:0] d,
    input  logic [SW-1:0] amount,
    input  logic          dir_right,
    input  logic          arith,
    output logic [BW-1:0] q
);

    logic          fill;
    logic [BW-1:0] stg [SW+1];

    assign fill   = arith & d[BW-1];
    assign stg[0] = d;

    // one stage per amount bit
    for (genvar i = 0; i < SW; i++) begin : g_stage
        localparam int SH = 1 << i;
        logic [BW-1:0] moved;

        assign moved = dir_right ? {{SH{fill}}, stg[i][BW-1:SH]}
                                 : {stg[i][BW-1-SH:0], {SH{1'b0}}};
        assign stg[i+1] = amount[i] ? moved : stg[i];
    end

    assign q = stg[SW];

    sra_keeps_sign: assert final (!(dir_right && arith) || (q[BW-1] == d[BW-1]));

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu #(
    parameter int BW = 8
) (
    input  logic [BW-1:0]    d1,
    input  logic [BW-1:0]    d2,
    input  alu_pkg::alu_op_e alu_op,
    input  logic             comp_flag,
    output logic [BW-1:0]    res,
    output logic             overflow
);
    import alu_pkg::*;

    localparam int SW = $clog2(BW);

    logic          sub;
    logic [BW-1:0] sum;
    logic          add_of;
    logic [BW-1:0] sh_q;
    logic          lt_s;
    logic          lt_u;
    logic          set_lt;

    // adder subtracts for sub, signed compare and ne
    assign sub = (alu_op == op_sub) || (alu_op == op_ne) ||
                 ((alu_op inside {op_slt, op_sltu}) && !comp_flag);

    // signs differ: d1 negative wins, else look at d1 - d2
    assign lt_s   = (d1[BW-1] != d2[BW-1]) ? d1[BW-1] : sum[BW-1];
    assign lt_u   = d1 < d2;
    assign set_lt = comp_flag ? lt_u : lt_s;

    always_comb begin
        res      = '0;
        overflow = 1'b0;
        case (alu_op)
            op_add, op_sub: begin
                res      = sum;
                overflow = add_of;
            end
            op_neg:  res = ~d1 + BW'(1);
            op_and:  res = d1 & d2;
            op_or:   res = d1 | d2;
            op_xor:  res = d1 ^ d2;
            op_slt, op_sltu: begin
                res = {BW{set_lt}};
            end
            op_ne:   res = {BW{|sum}};    // nonzero difference
            op_sll, op_srl, op_sra: begin
                res = sh_q;
            end
            default: res = '0;
        endcase
    end

    add_sub #(
        .BW       (BW)
    ) add_sub_inst0 (
        .sub      (sub),
        .a        (d1),
        .b        (d2),
        .sum      (sum),
        .overflow (add_of)
    );

    shifter #(
        .BW        (BW),
        .SW        (SW)
    ) shifter_inst0 (
        .d         (d1),
        .amount    (d2[SW-1:0]),    // amount mod BW
        .dir_right (alu_op == op_srl || alu_op == op_sra),
        .arith     (alu_op == op_sra),
        .q         (sh_q)
    );

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter int BW = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  alu_pkg::reg_addr_t wr_addr,
    input  logic [BW-1:0]      wr_data,
    input  alu_pkg::reg_addr_t rs1_addr,
    input  alu_pkg::reg_addr_t rs2_addr,
    output logic [BW-1:0]      rs1_data,
    output logic [BW-1:0]      rs2_data
);

    logic [BW-1:0] regs [8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 reads as zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    r0_stays_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        regs[0] == '0
    );

endmodule

// File: hdl/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl #(
    parameter int BW = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  alu_pkg::instr_t    instr,
    output alu_pkg::reg_addr_t rs1_addr,
    output alu_pkg::reg_addr_t rs2_addr,
    output alu_pkg::reg_addr_t wr_addr,
    output logic               wr_en,
    output logic               use_imm,
    output logic               comp_flag,
    output logic [BW-1:0]      imm_ext,
    output alu_pkg::alu_op_e   alu_op,
    output logic               res_valid
);
    import alu_pkg::*;

    logic op_known;

    assign use_imm  = instr.rr.is_imm;
    assign rs1_addr = instr.rr.rs1;    // same bits in both views
    assign wr_addr  = instr.rr.rd;

    always_comb begin
        if (use_imm) begin
            rs2_addr = '0;
            imm_ext  = {{(BW-5){instr.ri.imm[4]}}, instr.ri.imm};
        end else begin
            rs2_addr = instr.rr.rs2;
            imm_ext  = '0;
        end
    end

    assign alu_op    = alu_op_e'(instr.rr.op);
    assign op_known  = instr.rr.op <= 4'(op_sra);
    assign comp_flag = (alu_op == op_sltu);   // 1 = unsigned compare

    // r0 and unused codes never write
    assign wr_en = instr_valid && op_known && (wr_addr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= instr_valid;
        end
    end

endmodule

// File: hdl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit #(
    parameter int BW = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  alu_pkg::instr_t instr,
    output logic            res_valid,
    output logic [BW-1:0]   res,
    output logic            overflow
);
    import alu_pkg::*;

    reg_addr_t     rs1_addr;
    reg_addr_t     rs2_addr;
    reg_addr_t     wr_addr;
    logic          wr_en;
    logic          use_imm;
    logic          comp_flag;
    logic [BW-1:0] imm_ext;
    alu_op_e       alu_op;
    logic [BW-1:0] rs1_data;
    logic [BW-1:0] rs2_data;
    logic [BW-1:0] d2;
    logic [BW-1:0] alu_res;
    logic          alu_of;

    assign d2 = use_imm ? imm_ext : rs2_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res      <= '0;
            overflow <= 1'b0;
        end else if (instr_valid) begin
            res      <= alu_res;
            overflow <= alu_of;
        end
    end

    exec_ctrl #(
        .BW          (BW)
    ) exec_ctrl_inst0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .wr_addr     (wr_addr),
        .wr_en       (wr_en),
        .use_imm     (use_imm),
        .comp_flag   (comp_flag),
        .imm_ext     (imm_ext),
        .alu_op      (alu_op),
        .res_valid   (res_valid)
    );

    reg_file #(
        .BW       (BW)
    ) reg_file_inst0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (alu_res),    // write-back at the same edge
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu #(
        .BW        (BW)
    ) alu_inst0 (
        .d1        (rs1_data),
        .d2        (d2),
        .alu_op    (alu_op),
        .comp_flag (comp_flag),
        .res       (alu_res),
        .overflow  (alu_of)
    );

endmodule

// File: dv/tb_exec_unit.sv
`timescale 1ns/1ps

module tb_exec_unit;
    import alu_pkg::*;

    localparam int BW = 8;
    localparam int CLK_PERIOD = 100;
    localparam int LOAD_N = 2 * (BW / 4) - 1;    // instructions per loaded word
    localparam int NUM_INSTR = 14 + 8 * (2 * LOAD_N + 3) + 2 * (2 * LOAD_N + 1)
                             + 6 * (2 * LOAD_N + 6) + (2 * LOAD_N + 3)
                             + LOAD_N + 48 + 4 * (LOAD_N + 3) + (LOAD_N + 2) + 10;
    localparam logic [31:0]   LFSR_TAPS = 32'h80200003;
    localparam logic [BW-1:0] MSB = {1'b1, {(BW-1){1'b0}}};

    logic          clk;
    logic          rst_n;
    logic          instr_valid;
    instr_t        instr;
    logic          res_valid;
    logic [BW-1:0] res;
    logic          overflow;

    logic [31:0]   lfsr;
    logic [BW-1:0] model_regs [8];    // reference register file
    instr_t        chain_prog [6];

    exec_unit #(
        .BW          (BW)
    ) i_exec_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .res_valid   (res_valid),
        .res         (res),
        .overflow    (overflow)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [BW-1:0] exp,
                              input logic [BW-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ LFSR_TAPS;
        end
        return b;
    endfunction

    function automatic logic [BW-1:0] rand_word();
        logic [BW-1:0] w;
        for (int i = 0; i < BW; i++) begin
            w[i] = lfsr_bit();
        end
        return w;
    endfunction

    function automatic instr_t rr_instr(input logic [3:0] op, input reg_addr_t rd,
                                        input reg_addr_t rs1, input reg_addr_t rs2);
        instr_t w;
        w.rr.is_imm = 1'b0;
        w.rr.op     = op;
        w.rr.rd     = rd;
        w.rr.rs1    = rs1;
        w.rr.rs2    = rs2;
        w.rr.pad    = 2'b00;
        return w;
    endfunction

    function automatic instr_t ri_instr(input logic [3:0] op, input reg_addr_t rd,
                                        input reg_addr_t rs1, input logic [4:0] imm);
        instr_t w;
        w.ri.is_imm = 1'b1;
        w.ri.op     = op;
        w.ri.rd     = rd;
        w.ri.rs1    = rs1;
        w.ri.imm    = imm;
        return w;
    endfunction

    task automatic model_exec(input instr_t w, output logic [BW-1:0] r, output logic ovf);
        logic [BW-1:0] a;
        logic [BW-1:0] b;
        int sa;
        int sb;
        int amt;
        int lo;
        int hi;
        a   = model_regs[w.rr.rs1];
        b   = w.rr.is_imm ? BW'($signed(w.ri.imm)) : model_regs[w.rr.rs2];
        sa  = $signed(a);
        sb  = $signed(b);
        amt = b % BW;
        lo  = -(2 ** (BW - 1));
        hi  = 2 ** (BW - 1) - 1;
        r   = '0;
        ovf = 1'b0;
        case (w.rr.op)
            op_add: begin
                r   = a + b;
                ovf = (sa + sb < lo) || (sa + sb > hi);
            end
            op_sub: begin
                r   = a - b;
                ovf = (sa - sb < lo) || (sa - sb > hi);
            end
            op_neg:  r = '0 - a;
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            op_slt:  r = (sa < sb) ? {BW{1'b1}} : '0;
            op_sltu: r = (a < b) ? {BW{1'b1}} : '0;
            op_ne:   r = (a != b) ? {BW{1'b1}} : '0;
            op_sll:  r = a << amt;
            op_srl:  r = a >> amt;
            op_sra:  r = $signed(a) >>> amt;
            default: r = '0;
        endcase
        if (w.rr.op <= 4'd11 && w.rr.rd != 3'd0) begin
            model_regs[w.rr.rd] = r;
        end
    endtask

    task automatic verify_outputs(input logic [BW-1:0] exp_res, input logic exp_ovf);
        check_flag("res_valid", 1'b1, res_valid);
        check_word("res", exp_res, res);
        check_flag("overflow", exp_ovf, overflow);
    endtask

    task automatic exec_one(input instr_t w);
        logic [BW-1:0] exp_res;
        logic          exp_ovf;
        model_exec(w, exp_res, exp_ovf);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        @(negedge clk);
        check_flag("res_valid", 1'b0, res_valid);    // no pulse without an instruction
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        verify_outputs(exp_res, exp_ovf);
    endtask

    // one instruction per cycle, results checked one cycle behind
    task automatic run_chain(input int n);
        logic [BW-1:0] exp_res [8];
        logic          exp_ovf [8];
        for (int k = 0; k < n; k++) begin
            model_exec(chain_prog[k], exp_res[k], exp_ovf[k]);
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= chain_prog[k];
            if (k > 0) begin
                @(negedge clk);
                verify_outputs(exp_res[k-1], exp_ovf[k-1]);
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        verify_outputs(exp_res[n-1], exp_ovf[n-1]);
    endtask

    // builds a full word from 4-bit immediates
    task automatic load_word(input reg_addr_t rd, input logic [BW-1:0] value);
        for (int n = BW / 4 - 1; n >= 0; n--) begin
            if (n == BW / 4 - 1) begin
                exec_one(ri_instr(op_add, rd, 3'd0, {1'b0, value[4*n +: 4]}));
            end else begin
                exec_one(ri_instr(op_sll, rd, rd, 5'd4));
                exec_one(ri_instr(op_or, rd, rd, {1'b0, value[4*n +: 4]}));
            end
        end
    endtask

    task automatic reset_and_load();
        logic [4:0] imm;
        check_flag("res_valid", 1'b0, res_valid);
        check_word("res", '0, res);
        check_flag("overflow", 1'b0, overflow);
        for (int r = 1; r < 8; r++) begin
            imm = {r[0], lfsr_bit(), lfsr_bit(), lfsr_bit(), lfsr_bit()};    // odd regs negative
            exec_one(ri_instr(op_add, 3'(r), 3'd0, imm));
        end
        for (int r = 1; r < 8; r++) begin
            exec_one(rr_instr(op_or, 3'd0, 3'(r), 3'd0));
        end
    endtask

    task automatic arith_ops();
        for (int i = 0; i < 8; i++) begin
            load_word(3'd1, rand_word());
            load_word(3'd2, rand_word());
            exec_one(rr_instr(op_add, 3'd3, 3'd1, 3'd2));
            exec_one(rr_instr(op_sub, 3'd4, 3'd1, 3'd2));
            exec_one(rr_instr(op_neg, 3'd5, 3'd1, 3'd0));
        end
        load_word(3'd1, ~MSB);    // largest positive + 1
        load_word(3'd2, BW'(1));
        exec_one(rr_instr(op_add, 3'd3, 3'd1, 3'd2));
        check_flag("overflow", 1'b1, overflow);
        load_word(3'd1, MSB);    // most negative - 1
        load_word(3'd2, BW'(1));
        exec_one(rr_instr(op_sub, 3'd4, 3'd1, 3'd2));
        check_flag("overflow", 1'b1, overflow);
    endtask

    task automatic logic_compare();
        logic [BW-1:0] slt_r;
        for (int i = 0; i < 6; i++) begin
            load_word(3'd1, rand_word());
            load_word(3'd2, rand_word());
            exec_one(rr_instr(op_and, 3'd3, 3'd1, 3'd2));
            exec_one(rr_instr(op_or, 3'd4, 3'd1, 3'd2));
            exec_one(rr_instr(op_xor, 3'd5, 3'd1, 3'd2));
            exec_one(rr_instr(op_slt, 3'd6, 3'd1, 3'd2));
            exec_one(rr_instr(op_sltu, 3'd7, 3'd1, 3'd2));
            exec_one(rr_instr(op_ne, 3'd3, 3'd1, 3'd2));
        end
        load_word(3'd1, rand_word() | MSB);
        load_word(3'd2, rand_word() & ~MSB);
        exec_one(rr_instr(op_slt, 3'd6, 3'd1, 3'd2));
        slt_r = res;
        exec_one(rr_instr(op_sltu, 3'd7, 3'd1, 3'd2));
        check_flag("slt_vs_sltu", 1'b1, slt_r != res);    // signs differ
        exec_one(rr_instr(op_ne, 3'd3, 3'd1, 3'd1));
    endtask

    task automatic shift_ops();
        load_word(3'd1, rand_word());
        for (int a = 0; a < 16; a++) begin
            exec_one(ri_instr(op_sll, 3'd2, 3'd1, 5'(a)));
            exec_one(ri_instr(op_srl, 3'd3, 3'd1, 5'(a)));
            exec_one(ri_instr(op_sra, 3'd4, 3'd1, 5'(a)));
        end
        for (int i = 0; i < 4; i++) begin
            load_word(3'd2, rand_word());    // amount wraps mod BW
            exec_one(rr_instr(op_sll, 3'd5, 3'd1, 3'd2));
            exec_one(rr_instr(op_srl, 3'd6, 3'd1, 3'd2));
            exec_one(rr_instr(op_sra, 3'd7, 3'd1, 3'd2));
        end
        load_word(3'd6, rand_word() | MSB);
        exec_one(ri_instr(op_sra, 3'd7, 3'd6, 5'd3));
        check_flag("sra_fill", 1'b1, &res[BW-1 -: 4]);
        exec_one(ri_instr(op_sra, 3'd7, 3'd6, 5'(BW - 1)));
    endtask

    task automatic chain_and_suppress();
        chain_prog[0] = ri_instr(op_add, 3'd1, 3'd0, 5'd5);
        chain_prog[1] = rr_instr(op_add, 3'd2, 3'd1, 3'd1);
        chain_prog[2] = rr_instr(op_sub, 3'd3, 3'd2, 3'd1);
        chain_prog[3] = ri_instr(op_xor, 3'd4, 3'd3, 5'h1f);
        chain_prog[4] = rr_instr(op_or, 3'd5, 3'd4, 3'd2);
        chain_prog[5] = ri_instr(op_sra, 3'd6, 3'd5, 5'd1);
        run_chain(6);
        exec_one(rr_instr(op_add, 3'd0, 3'd6, 3'd6));    // r0 target
        exec_one(ri_instr(4'd13, 3'd1, 3'd2, 5'd0));     // unused opcode
        exec_one(rr_instr(op_or, 3'd0, 3'd1, 3'd0));
        exec_one(rr_instr(op_or, 3'd0, 3'd6, 3'd0));
    endtask

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr        = 32'ha62e8996;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        reset_and_load();
        arith_ops();
        logic_compare();
        shift_ops();
        chain_and_suppress();
        $display("TB PASSED");
        $finish;
    end

    initial begin
        #((NUM_INSTR * 4 + 10) * CLK_PERIOD);
        stop_on_error("watchdog timeout, the tests did not finish in time");
    end

endmodule

// File: files.f
hdl/alu_pkg.sv
hdl/add_sub.sv
hdl/shifter.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/exec_ctrl.sv
hdl/exec_unit.sv
dv/tb_exec_unit.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - files:
      - hdl/alu_pkg.sv
      - hdl/add_sub.sv
      - hdl/shifter.sv
      - hdl/alu.sv
      - hdl/reg_file.sv
      - hdl/exec_ctrl.sv
      - hdl/exec_unit.sv
  - target: test
    files:
      - dv/tb_exec_unit.sv
